// ==== Makefile ====
# Verilator build and run for the CNN output alignment stage

VERILATOR ?= verilator
TOP       ?= tb_conv_align
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
FILE_LIST := compile.f
FAIL_MSG  := *** TEST FAILED ***

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(OBJ_DIR)/V%: $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $* -Mdir $(OBJ_DIR) -o V$*

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
verilog/cnn_data_pkg.sv
verilog/cnn_geom_pkg.sv
verilog/pixel_position_tracker.sv
verilog/stride2_select.sv
verilog/max_pool2x2.sv
verilog/output_credit_fifo.sv
verilog/conv_align_stride2_output.sv
sim/conv_align_asserts.sv
sim/tb_checker.sv
sim/tb_conv_align.sv

// ==== sim/conv_align_asserts.sv ====
`timescale 1ns/100ps

module conv_align_asserts #(
	parameter int CREDITS = 4,
	parameter int CRED_W  = 3
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              valid_out,
	input  logic              credit_return,
	input  logic [CRED_W-1:0] credits,
	input  logic              overflow
);

	int fail_count = 0;
	// Pixels sent downstream whose credit has not come back yet
	int in_flight;

	always_ff @(posedge clk) begin
		if (reset) begin
			in_flight <= 0;
		end else begin
			in_flight <= in_flight + int'(valid_out) - int'(credit_return);
		end
	end

	// Nothing leaves the FIFO unless downstream has room
	send_needs_credit: assert property (
		@(posedge clk) disable iff (reset) valid_out |-> (in_flight < CREDITS)
	) else begin
		$error("valid_out high with all %0d credits already in flight", CREDITS);
		fail_count++;
	end

	// Downstream never hands back more than it was given
	credit_ceiling: assert property (
		@(posedge clk) disable iff (reset) credits <= CRED_W'(CREDITS)
	) else begin
		$error("credit count %0d above the initial %0d", credits, CREDITS);
		fail_count++;
	end

	// Sticky until the next reset
	overflow_sticky: assert property (
		@(posedge clk) (overflow && !reset) |=> overflow
	) else begin
		$error("overflow fell without a reset");
		fail_count++;
	end

endmodule

bind output_credit_fifo conv_align_asserts #(
	.CREDITS(CREDITS),
	.CRED_W (CRED_W)
) i_conv_align_asserts (
	.clk          (clk),
	.reset        (reset),
	.valid_out    (valid_out),
	.credit_return(credit_return),
	.credits      (credits),
	.overflow     (overflow)
);

// ==== sim/tb_checker.sv ====
`timescale 1ns/100ps

module tb_checker
	import cnn_geom_pkg::*,
	       cnn_data_pkg::*;
#(
	parameter int IMAGE_WIDTH  = DEFAULT_IMAGE_WIDTH,
	parameter int IMAGE_HEIGHT = DEFAULT_IMAGE_HEIGHT,
	parameter int FIFO_DEPTH   = 8,
	parameter int CREDITS      = 4
) (
	input  logic        clk,
	input  logic        reset,
	input  align_mode_t mode,
	input  pixel_t      pxl_in,
	input  logic        valid_in,
	input  pixel_t      pxl_out,
	input  logic        valid_out,
	input  logic        overflow,
	input  int          test_id,
	input  logic        credit_hold,
	input  logic        lossy,
	input  logic        final_check,
	output logic        done,
	output int          error_count,
	output int          checked
);

	pixel_t      plane_buf [IMAGE_HEIGHT][IMAGE_WIDTH];
	pixel_t      exp_q [$];
	int          exp_test_q [$];
	int          m_col;
	int          m_row;
	align_mode_t m_mode;
	int          hold_outputs;
	int          lossy_outputs;
	logic        overflow_seen;

	function automatic string test_name(input int id);
		case (id)
			1:       return "pass";
			2:       return "stride2";
			3:       return "maxpool";
			4:       return "mode_change";
			5:       return "credit_starvation";
			6:       return "overflow";
			default: return "idle";
		endcase
	endfunction

	task automatic push_expected(input pixel_t value);
		exp_q.push_back(value);
		exp_test_q.push_back(test_id);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model, one step per input pixel
	////////////////////////////////////////////////////////////////////////////

	task automatic model_pixel();
		pixel_t win;
		// Mode only counts at the origin pixel
		if (m_col == 0 && m_row == 0) begin
			m_mode = mode;
		end
		plane_buf[m_row][m_col] = pxl_in;
		if (m_mode == mode_pass) begin
			push_expected(pxl_in);
		end else if (m_mode == mode_stride2 && m_row % 2 == 0 && m_col % 2 == 0) begin
			push_expected(pxl_in);
		end else if (m_mode == mode_maxpool && m_row % 2 == 1 && m_col % 2 == 1) begin
			win = pixel_max(pixel_max(plane_buf[m_row-1][m_col-1], plane_buf[m_row-1][m_col]),
			                pixel_max(plane_buf[m_row][m_col-1], pxl_in));
			push_expected(win);
		end
		m_col++;
		if (m_col == IMAGE_WIDTH) begin
			m_col = 0;
			m_row = (m_row + 1) % IMAGE_HEIGHT;
		end
	endtask

	task automatic compare_output();
		pixel_t expected;
		int     id;
		if (exp_q.size() == 0) begin
			$display("Output pixel %0d in test %s arrived with nothing due",
			         pxl_out, test_name(test_id));
			error_count++;
		end else begin
			expected = exp_q.pop_front();
			id       = exp_test_q.pop_front();
			checked++;
			if (pxl_out !== expected) begin
				$display("MISMATCH test=%s expected=%0d actual=%0d",
				         test_name(id), expected, pxl_out);
				error_count++;
			end
			if (lossy) begin
				lossy_outputs++;
			end
		end
	endtask

	task automatic check_flags();
		if (credit_hold) begin
			if (valid_out) begin
				hold_outputs++;
			end
			if (valid_out && hold_outputs == CREDITS + 1) begin
				$display("More than %0d pixels sent in test %s while credits were withheld",
				         CREDITS, test_name(test_id));
				error_count++;
			end
		end else begin
			hold_outputs = 0;
		end
		if (!lossy && overflow && !overflow_seen) begin
			$display("Overflow raised in test %s although credits were flowing",
			         test_name(test_id));
			overflow_seen = 1'b1;
			error_count++;
		end
	endtask

	task automatic finish_checks();
		if (lossy) begin
			if (!overflow) begin
				$display("Overflow flag low after dense input with credits withheld");
				error_count++;
			end
			// Pixels already sent plus a full FIFO survive
			if (lossy_outputs != FIFO_DEPTH + CREDITS) begin
				$display("MISMATCH test=%s expected=%0d actual=%0d",
				         test_name(6), FIFO_DEPTH + CREDITS, lossy_outputs);
				error_count++;
			end
			exp_q.delete();
			exp_test_q.delete();
		end else if (exp_q.size() != 0) begin
			$display("%0d expected pixels never came out", exp_q.size());
			error_count++;
		end
		done = 1'b1;
	endtask

	always @(posedge clk) begin
		if (reset) begin
			m_col         = 0;
			m_row         = 0;
			m_mode        = mode_pass;
			hold_outputs  = 0;
			lossy_outputs = 0;
			overflow_seen = 1'b0;
			error_count   = 0;
			checked       = 0;
			done          = 1'b0;
		end else begin
			if (valid_out) begin
				compare_output();
			end
			if (valid_in) begin
				model_pixel();
			end
			check_flags();
			if (final_check && !done) begin
				finish_checks();
			end
		end
	end

endmodule

// ==== sim/tb_conv_align.sv ====
`timescale 1ns/100ps

module tb_conv_align
	import cnn_geom_pkg::*,
	       cnn_data_pkg::*;
();

	localparam int IMAGE_WIDTH  = DEFAULT_IMAGE_WIDTH;
	localparam int IMAGE_HEIGHT = DEFAULT_IMAGE_HEIGHT;
	localparam int FIFO_DEPTH   = 8;
	localparam int CREDITS      = 4;
	localparam int PIXELS       = IMAGE_WIDTH * IMAGE_HEIGHT;
	// Three single planes, three back to back, starvation and overflow
	localparam int PLANES         = 8;
	localparam int TIMEOUT_CYCLES = PLANES * PIXELS * 4 + 200;
	localparam logic [31:0] SEED  = 32'h88bb_231a;

	logic        clk;
	logic        reset;
	align_mode_t mode;
	pixel_t      pxl_in;
	logic        valid_in;
	pixel_t      pxl_out;
	logic        valid_out;
	logic        credit_return = 1'b0;
	logic        overflow;

	int          test_id;
	logic        credit_hold;
	logic        lossy;
	logic        final_check;
	logic        done;
	int          error_count;
	int          checked;
	int          cycle_count = 0;

	logic [31:0] stim_state   = SEED;
	logic [31:0] credit_state = {SEED[15:0], SEED[31:16]};
	pixel_t      held_pxl_q [$];
	int          release_q [$];

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	always #10 clk = ~clk;

	conv_align_stride2_output #(
		.IMAGE_WIDTH (IMAGE_WIDTH),
		.IMAGE_HEIGHT(IMAGE_HEIGHT),
		.FIFO_DEPTH  (FIFO_DEPTH),
		.CREDITS     (CREDITS)
	) i_conv_align_stride2_output (
		.clk          (clk),
		.reset        (reset),
		.mode         (mode),
		.pxl_in       (pxl_in),
		.valid_in     (valid_in),
		.pxl_out      (pxl_out),
		.valid_out    (valid_out),
		.credit_return(credit_return),
		.overflow     (overflow)
	);

	tb_checker #(
		.IMAGE_WIDTH (IMAGE_WIDTH),
		.IMAGE_HEIGHT(IMAGE_HEIGHT),
		.FIFO_DEPTH  (FIFO_DEPTH),
		.CREDITS     (CREDITS)
	) i_tb_checker (
		.clk        (clk),
		.reset      (reset),
		.mode       (mode),
		.pxl_in     (pxl_in),
		.valid_in   (valid_in),
		.pxl_out    (pxl_out),
		.valid_out  (valid_out),
		.overflow   (overflow),
		.test_id    (test_id),
		.credit_hold(credit_hold),
		.lossy      (lossy),
		.final_check(final_check),
		.done       (done),
		.error_count(error_count),
		.checked    (checked)
	);

	////////////////////////////////////////////////////////////////////////////
	// Downstream layer, hands each credit back after a short random delay
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (reset) begin
			credit_return <= 1'b0;
		end else begin
			credit_state = xorshift32(credit_state);
			if (valid_out) begin
				held_pxl_q.push_back(pxl_out);
				release_q.push_back(cycle_count + int'(credit_state[1:0]));
			end
			if (!credit_hold && release_q.size() > 0 && release_q[0] <= cycle_count) begin
				credit_return <= 1'b1;
				void'(held_pxl_q.pop_front());
				void'(release_q.pop_front());
			end else begin
				credit_return <= 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the output stream never drained", cycle_count);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// One plane in raster order, credits withheld for the first hold_pixels
	task automatic drive_plane(input align_mode_t plane_kind, input logic dense,
	                           input int hold_pixels);
		int n;
		n = 0;
		while (n < PIXELS) begin
			@(posedge clk);
			stim_state = xorshift32(stim_state);
			if (dense || stim_state[0]) begin
				valid_in    <= 1'b1;
				pxl_in      <= pixel_t'(stim_state[31:16]);
				mode        <= plane_kind;
				credit_hold <= (n < hold_pixels);
				n++;
			end else begin
				valid_in <= 1'b0;
			end
		end
		@(posedge clk);
		valid_in <= 1'b0;
	endtask

	// All credits home and nothing left to send
	task automatic wait_drain();
		int quiet;
		quiet = 0;
		while (quiet < 4) begin
			@(negedge clk);
			if (!valid_out && held_pxl_q.size() == 0) begin
				quiet++;
			end else begin
				quiet = 0;
			end
		end
	endtask

	initial begin
		int          assert_failures;
		int          i;
		align_mode_t next_mode;
		clk         = 1'b0;
		reset       = 1'b1;
		mode        = mode_pass;
		pxl_in      = '0;
		valid_in    = 1'b0;
		test_id     = 0;
		credit_hold = 1'b0;
		lossy       = 1'b0;
		final_check = 1'b0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		test_id <= 1;
		drive_plane(mode_pass, 1'b0, 0);
		wait_drain();
		test_id <= 2;
		drive_plane(mode_stride2, 1'b0, 0);
		wait_drain();
		test_id <= 3;
		drive_plane(mode_maxpool, 1'b0, 0);
		wait_drain();

		// Back to back planes, each with a different mode
		test_id <= 4;
		next_mode = mode_maxpool;
		for (i = 0; i < 3; i++) begin
			stim_state = xorshift32(stim_state);
			next_mode  = align_mode_t'((int'(next_mode) + 1 + int'(stim_state[0])) % 3);
			drive_plane(next_mode, 1'b0, 0);
		end
		wait_drain();

		// First two rows of pooling give eight windows, only four credits
		test_id <= 5;
		drive_plane(mode_maxpool, 1'b0, 2 * IMAGE_WIDTH);
		wait_drain();

		test_id <= 6;
		lossy   <= 1'b1;
		drive_plane(mode_pass, 1'b1, PIXELS);
		repeat (2) @(posedge clk);
		credit_hold <= 1'b0;
		wait_drain();

		final_check <= 1'b1;
		wait (done);
		assert_failures =
			i_conv_align_stride2_output.i_output_credit_fifo.i_conv_align_asserts.fail_count;
		$display("Result: %0d pixels compared, %0d check errors, %0d assertion failures",
		         checked, error_count, assert_failures);
		if (error_count == 0 && assert_failures == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== verilog/cnn_data_pkg.sv ====
package cnn_data_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Activation word coming out of the convolution engine
	////////////////////////////////////////////////////////////////////////////

	localparam int PIXEL_WIDTH = 16;

	// Signed so that pooling compares negative activations correctly
	typedef logic signed [PIXEL_WIDTH-1:0] pixel_t;

	// Larger of two activations, ties keep the first one
	function automatic pixel_t pixel_max(input pixel_t a, input pixel_t b);
		pixel_t result;
		if (b > a) begin
			result = b;
		end else begin
			result = a;
		end
		return result;
	endfunction

endpackage

// ==== verilog/cnn_geom_pkg.sv ====
package cnn_geom_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Alignment mode, held constant over one channel plane
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		// Every pixel goes through
		mode_pass    = 2'd0,
		// Keep even row, even column
		mode_stride2 = 2'd1,
		// One maximum per 2x2 window
		mode_maxpool = 2'd2
	} align_mode_t;

	////////////////////////////////////////////////////////////////////////////
	// Default plane geometry
	////////////////////////////////////////////////////////////////////////////

	// Both must be even and at least 4
	localparam int DEFAULT_IMAGE_WIDTH  = 16;
	localparam int DEFAULT_IMAGE_HEIGHT = 8;

endpackage

// ==== verilog/conv_align_stride2_output.sv ====
`timescale 1ns/100ps

module conv_align_stride2_output
	import cnn_geom_pkg::*,
	       cnn_data_pkg::*;
#(
	parameter int IMAGE_WIDTH  = DEFAULT_IMAGE_WIDTH,
	parameter int IMAGE_HEIGHT = DEFAULT_IMAGE_HEIGHT,
	parameter int FIFO_DEPTH   = 8,
	parameter int CREDITS      = 4
) (
	input  logic        clk,
	input  logic        reset,
	input  align_mode_t mode,
	input  pixel_t      pxl_in,
	input  logic        valid_in,
	output pixel_t      pxl_out,
	output logic        valid_out,
	input  logic        credit_return,
	output logic        overflow
);

	logic [$clog2(IMAGE_WIDTH)-1:0]  col;
	logic [$clog2(IMAGE_HEIGHT)-1:0] row;
	logic                            plane_first;
	align_mode_t                     plane_mode;

	logic   sel_valid;
	pixel_t sel_pxl;
	logic   pool_valid;
	pixel_t pool_pxl;
	logic   wr_valid;
	pixel_t wr_pxl;

	pixel_position_tracker #(
		.IMAGE_WIDTH (IMAGE_WIDTH),
		.IMAGE_HEIGHT(IMAGE_HEIGHT)
	) i_pixel_position_tracker (
		.clk        (clk),
		.reset      (reset),
		.valid_in   (valid_in),
		.col        (col),
		.row        (row),
		.plane_first(plane_first)
	);

	stride2_select i_stride2_select (
		.clk        (clk),
		.reset      (reset),
		.mode       (mode),
		.valid_in   (valid_in),
		.pxl_in     (pxl_in),
		.col        (col[0]),
		.row        (row[0]),
		.plane_first(plane_first),
		.plane_mode (plane_mode),
		.sel_valid  (sel_valid),
		.sel_pxl    (sel_pxl)
	);

	max_pool2x2 #(
		.IMAGE_WIDTH(IMAGE_WIDTH)
	) i_max_pool2x2 (
		.clk       (clk),
		.reset     (reset),
		.plane_mode(plane_mode),
		.valid_in  (valid_in),
		.pxl_in    (pxl_in),
		.col       (col),
		.row       (row[0]),
		.pool_valid(pool_valid),
		.pool_pxl  (pool_pxl)
	);

	// A plane feeds only one path, so the strobes never collide
	assign wr_valid = sel_valid | pool_valid;
	assign wr_pxl   = pool_valid ? pool_pxl : sel_pxl;

	output_credit_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.CREDITS   (CREDITS)
	) i_output_credit_fifo (
		.clk          (clk),
		.reset        (reset),
		.wr_valid     (wr_valid),
		.wr_pxl       (wr_pxl),
		.credit_return(credit_return),
		.pxl_out      (pxl_out),
		.valid_out    (valid_out),
		.overflow     (overflow)
	);

endmodule

// ==== verilog/max_pool2x2.sv ====
`timescale 1ns/100ps

module max_pool2x2
	import cnn_geom_pkg::*,
	       cnn_data_pkg::*;
#(
	parameter int IMAGE_WIDTH = DEFAULT_IMAGE_WIDTH
) (
	input  logic                           clk,
	input  logic                           reset,
	input  align_mode_t                    plane_mode,
	input  logic                           valid_in,
	input  pixel_t                         pxl_in,
	input  logic [$clog2(IMAGE_WIDTH)-1:0] col,
	// Row parity selects store or combine
	input  logic                           row,
	output logic                           pool_valid,
	output pixel_t                         pool_pxl
);

	localparam int COL_W      = $clog2(IMAGE_WIDTH);
	localparam int HALF_WIDTH = IMAGE_WIDTH / 2;

	////////////////////////////////////////////////////////////////////////////
	// Half-width row memory, one pair maximum per window column
	////////////////////////////////////////////////////////////////////////////

	pixel_t row_mem [HALF_WIDTH];

	pixel_t            left_pxl;
	pixel_t            pair_max;
	pixel_t            window_max;
	logic [COL_W-2:0]  win_idx;
	logic              active;
	logic              pair_done;

	assign active    = valid_in && (plane_mode == mode_maxpool);
	// Odd column closes a horizontal pair
	assign pair_done = active && col[0];
	assign win_idx   = col[COL_W-1:1];

	assign pair_max   = pixel_max(left_pxl, pxl_in);
	assign window_max = pixel_max(row_mem[win_idx], pair_max);

	// Even column, hold the left half of the pair
	always_ff @(posedge clk) begin
		if (active && !col[0]) begin
			left_pxl <= pxl_in;
		end
	end

	// Upper row of the window parks its pair maximum
	always_ff @(posedge clk) begin
		if (pair_done && !row) begin
			row_mem[win_idx] <= pair_max;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Window result, at the odd row and odd column pixel
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			pool_valid <= 1'b0;
		end else begin
			pool_valid <= pair_done && row;
		end
	end

	always_ff @(posedge clk) begin
		if (pair_done && row) begin
			pool_pxl <= window_max;
		end
	end

endmodule

// ==== verilog/output_credit_fifo.sv ====
`timescale 1ns/100ps

module output_credit_fifo
	import cnn_data_pkg::*;
#(
	parameter int FIFO_DEPTH = 8,
	parameter int CREDITS    = 4
) (
	input  logic   clk,
	input  logic   reset,
	input  logic   wr_valid,
	input  pixel_t wr_pxl,
	input  logic   credit_return,
	output pixel_t pxl_out,
	output logic   valid_out,
	output logic   overflow
);

	localparam int PTR_W  = $clog2(FIFO_DEPTH);
	localparam int CRED_W = $clog2(CREDITS + 1);

	localparam logic [PTR_W:0]    FULL_COUNT   = (PTR_W + 1)'(FIFO_DEPTH);
	localparam logic [CRED_W-1:0] INIT_CREDITS = CRED_W'(CREDITS);

	pixel_t mem [FIFO_DEPTH];

	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [PTR_W:0]    count;
	logic [CRED_W-1:0] credits;

	logic full;
	logic wr_accept;
	logic send;

	assign full      = (count == FULL_COUNT);
	assign wr_accept = wr_valid && !full;

	// Head goes out as soon as it exists and downstream has room
	assign send      = (count != '0) && (credits != '0);
	assign valid_out = send;
	assign pxl_out   = mem[rd_ptr];

	////////////////////////////////////////////////////////////////////////////
	// Storage and pointers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wr_accept) begin
			mem[wr_ptr] <= wr_pxl;
		end
	end

	// Depth is a power of two, pointers wrap on their own
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_accept) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (send) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_accept, send})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Credits toward the next layer, and the sticky overflow flag
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			credits <= INIT_CREDITS;
		end else begin
			case ({send, credit_return})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// Input side has no back-pressure, a full FIFO loses the pixel
	always_ff @(posedge clk) begin
		if (reset) begin
			overflow <= 1'b0;
		end else if (wr_valid && full) begin
			overflow <= 1'b1;
		end
	end

endmodule

// ==== verilog/pixel_position_tracker.sv ====
`timescale 1ns/100ps

module pixel_position_tracker
	import cnn_geom_pkg::*;
#(
	parameter int IMAGE_WIDTH  = DEFAULT_IMAGE_WIDTH,
	parameter int IMAGE_HEIGHT = DEFAULT_IMAGE_HEIGHT
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            valid_in,
	output logic [$clog2(IMAGE_WIDTH)-1:0]  col,
	output logic [$clog2(IMAGE_HEIGHT)-1:0] row,
	output logic                            plane_first
);

	localparam int COL_W = $clog2(IMAGE_WIDTH);
	localparam int ROW_W = $clog2(IMAGE_HEIGHT);

	localparam logic [COL_W-1:0] LAST_COL = COL_W'(IMAGE_WIDTH - 1);
	localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(IMAGE_HEIGHT - 1);

	logic last_col;
	logic plane_last;

	// col and row always name the pixel currently on pxl_in
	assign last_col   = (col == LAST_COL);
	assign plane_last = last_col && (row == LAST_ROW);

	////////////////////////////////////////////////////////////////////////////
	// Raster counters, advanced once per valid pixel
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			col <= '0;
			row <= '0;
		end else if (valid_in) begin
			if (plane_last) begin
				// Next plane starts at the origin again
				col <= '0;
				row <= '0;
			end else if (last_col) begin
				col <= '0;
				row <= row + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// Origin pixel of a plane, only while it is actually presented
	assign plane_first = valid_in && (col == '0) && (row == '0);

endmodule

// ==== verilog/stride2_select.sv ====
`timescale 1ns/100ps

module stride2_select
	import cnn_geom_pkg::*,
	       cnn_data_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  align_mode_t mode,
	input  logic        valid_in,
	input  pixel_t      pxl_in,
	// Only the parity of the position is needed here
	input  logic        col,
	input  logic        row,
	input  logic        plane_first,
	output align_mode_t plane_mode,
	output logic        sel_valid,
	output pixel_t      sel_pxl
);

	align_mode_t mode_q;
	logic        keep;

	// First pixel of a plane already follows the new mode
	assign plane_mode = plane_first ? mode : mode_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			mode_q <= mode_pass;
		end else if (plane_first) begin
			mode_q <= mode;
		end
	end

	// Pooling planes are handled by the other path
	assign keep = valid_in &&
	              ((plane_mode == mode_pass) ||
	               ((plane_mode == mode_stride2) && !col && !row));

	always_ff @(posedge clk) begin
		if (reset) begin
			sel_valid <= 1'b0;
		end else begin
			sel_valid <= keep;
		end
	end

	always_ff @(posedge clk) begin
		if (keep) begin
			sel_pxl <= pxl_in;
		end
	end

endmodule
